// ==== hw/core_alu.sv ====
`include "core_cfg.svh"

module core_alu (
	input  core_pkg::alu_op      op,
	input  logic [`CORE_W-1:0]   a,
	input  logic [`CORE_W-1:0]   b,
	input  logic                 c_in,
	input  logic                 c_shift,
	output logic [`CORE_W-1:0]   q,
	output core_pkg::psr_flags   nzcv,
	output logic                 v_valid
);

	logic               c;
	logic               v;
	logic               c_add;
	logic               c_sub;
	logic               c_rsb;
	logic               v_add;
	logic               v_sub;
	logic               v_rsb;
	logic [`CORE_W-1:0] q_add;
	logic [`CORE_W-1:0] q_sub;
	logic [`CORE_W-1:0] q_rsb;

	// ***********************************************************************
	// Adders
	// ***********************************************************************

	// Carry in only for ADC.
	core_alu_add #(.W(`CORE_W), .SUB(1'b0)) i_add (
		.a    (a),
		.b    (b),
		.c_in (c_in && (op == core_pkg::ADC)),
		.q    (q_add),
		.c    (c_add),
		.v    (v_add)
	);

	// Borrow is the inverted PSR carry.
	core_alu_add #(.W(`CORE_W), .SUB(1'b1)) i_sub (
		.a    (a),
		.b    (b),
		.c_in (!c_in && (op == core_pkg::SBC)),
		.q    (q_sub),
		.c    (c_sub),
		.v    (v_sub)
	);

	// Reverse subtract, b - a.
	core_alu_add #(.W(`CORE_W), .SUB(1'b1)) i_rsb (
		.a    (b),
		.b    (a),
		.c_in (!c_in && (op == core_pkg::RSC)),
		.q    (q_rsb),
		.c    (c_rsb),
		.v    (v_rsb)
	);

	// ***********************************************************************
	// Result select
	// ***********************************************************************

	always_comb begin
		unique case (op)
			core_pkg::ADD, core_pkg::ADC, core_pkg::CMN: begin
				q       = q_add;
				c       = c_add;
				v       = v_add;
				v_valid = 1'b1;
			end

			core_pkg::SUB, core_pkg::SBC, core_pkg::CMP: begin
				q       = q_sub;
				c       = c_sub;
				v       = v_sub;
				v_valid = 1'b1;
			end

			core_pkg::RSB, core_pkg::RSC: begin
				q       = q_rsb;
				c       = c_rsb;
				v       = v_rsb;
				v_valid = 1'b1;
			end

			// Logical ops take C from the shifter.
			core_pkg::AND, core_pkg::TST, core_pkg::BIC, core_pkg::EOR,
			core_pkg::TEQ, core_pkg::ORR, core_pkg::MOV, core_pkg::MVN: begin
				unique case (op)
					core_pkg::AND, core_pkg::TST: q = a & b;
					core_pkg::BIC:                q = a & ~b;
					core_pkg::EOR, core_pkg::TEQ: q = a ^ b;
					core_pkg::ORR:                q = a | b;
					core_pkg::MOV:                q = b;
					default:                      q = ~b;
				endcase
				c       = c_shift;
				v       = 1'b0;
				v_valid = 1'b0;
			end
		endcase
	end

	assign nzcv = '{n: q[`CORE_W-1], z: (q == '0), c: c, v: v};

endmodule

// ==== hw/core_alu_add.sv ====
module core_alu_add #(
	parameter int W   = 16,
	parameter bit SUB = 1'b0
) (
	input  logic [W-1:0] a,
	input  logic [W-1:0] b,
	input  logic         c_in,
	output logic [W-1:0] q,
	output logic         c,
	output logic         v
);

	logic [W-1:0] b_eff;
	logic         cin_eff;

	// Subtract as a + ~b + 1, less one more on borrow.
	assign b_eff   = SUB ? ~b : b;
	assign cin_eff = SUB ? ~c_in : c_in;

	// Carry out doubles as ARM "not borrow" when subtracting.
	assign {c, q} = {1'b0, a} + {1'b0, b_eff} + {{W{1'b0}}, cin_eff};

	// Overflow when both addends agree in sign but the sum does not.
	assign v = (a[W-1] == b_eff[W-1]) && (q[W-1] != a[W-1]);

endmodule

// ==== hw/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ***************************************************************************
// Datapath sizing
// ***************************************************************************

// Register and operand width.
`define CORE_W 16

// Immediate shift amount width, covers 0 to CORE_W-1.
`define CORE_SHW 4

`endif

// ==== hw/core_exec.sv ====
`include "core_cfg.svh"

module core_exec (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req_valid,
	input  core_pkg::dp_req      req,
	output logic                 res_valid,
	output core_pkg::dp_result   res,
	output core_pkg::psr_flags   flags
);

	logic [`CORE_W-1:0] shift_q;
	logic               shift_c;
	logic [`CORE_W-1:0] alu_q;
	core_pkg::psr_flags alu_nzcv;
	logic               alu_v_valid;
	logic               is_cmp;
	logic               flags_load;

	// ***********************************************************************
	// Operand 2 and ALU
	// ***********************************************************************

	core_shifter i_shifter (
		.value (req.b),
		.shift (req.shift),
		.shamt (req.shamt),
		.c_in  (flags.c),
		.q     (shift_q),
		.c     (shift_c)
	);

	core_alu i_alu (
		.op      (req.op),
		.a       (req.a),
		.b       (shift_q),
		.c_in    (flags.c),
		.c_shift (shift_c),
		.q       (alu_q),
		.nzcv    (alu_nzcv),
		.v_valid (alu_v_valid)
	);

	// Compares set flags unconditionally and never write back.
	assign is_cmp = (req.op == core_pkg::TST) || (req.op == core_pkg::TEQ) ||
		(req.op == core_pkg::CMP) || (req.op == core_pkg::CMN);

	assign flags_load = req_valid && (req.set_flags || is_cmp);

	// ***********************************************************************
	// Result and PSR registers
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			res       <= '0;
			flags     <= '0;
		end else begin
			res_valid <= req_valid;

			if (req_valid) begin
				res.q     <= alu_q;
				res.write <= !is_cmp;
			end

			if (flags_load) begin
				flags.n <= alu_nzcv.n;
				flags.z <= alu_nzcv.z;
				flags.c <= alu_nzcv.c;
				// V untouched by logical ops.
				flags.v <= alu_v_valid ? alu_nzcv.v : flags.v;
			end
		end
	end

endmodule

// ==== hw/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

	// ***********************************************************************
	// Opcodes
	// ***********************************************************************

	// Data-processing opcodes in ARM encoding order.
	typedef enum logic [3:0] {
		AND = 4'h0,
		EOR = 4'h1,
		SUB = 4'h2,
		RSB = 4'h3,
		ADD = 4'h4,
		ADC = 4'h5,
		SBC = 4'h6,
		RSC = 4'h7,
		TST = 4'h8,
		TEQ = 4'h9,
		CMP = 4'ha,
		CMN = 4'hb,
		ORR = 4'hc,
		MOV = 4'hd,
		BIC = 4'he,
		MVN = 4'hf
	} alu_op;

	typedef enum logic [1:0] {
		LSL = 2'b00,
		LSR = 2'b01,
		ASR = 2'b10,
		ROR = 2'b11
	} shift_op;

	// ***********************************************************************
	// Datapath bundles
	// ***********************************************************************

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		logic                  set_flags;
		alu_op                 op;
		logic [`CORE_W-1:0]    a;
		logic [`CORE_W-1:0]    b;
		shift_op               shift;
		logic [`CORE_SHW-1:0]  shamt;
	} dp_req;

	typedef struct packed {
		logic [`CORE_W-1:0] q;
		logic               write;
	} dp_result;

endpackage

// ==== hw/core_shifter.sv ====
`include "core_cfg.svh"

module core_shifter (
	input  logic [`CORE_W-1:0]    value,
	input  core_pkg::shift_op     shift,
	input  logic [`CORE_SHW-1:0]  shamt,
	input  logic                  c_in,
	output logic [`CORE_W-1:0]    q,
	output logic                  c
);

	logic [`CORE_W-1:0] q_lsl;
	logic [`CORE_W-1:0] q_lsr;
	logic [`CORE_W-1:0] q_asr;
	logic [`CORE_W-1:0] q_ror;

	// ***********************************************************************
	// Shift candidates
	// ***********************************************************************

	assign q_lsl = value << shamt;
	assign q_lsr = value >> shamt;
	assign q_asr = $signed(value) >>> shamt;

	// Only selected for nonzero amounts.
	assign q_ror = (value >> shamt) | (value << (`CORE_W - shamt));

	// ***********************************************************************
	// Result and carry select
	// ***********************************************************************

	always_comb begin
		if (shamt == '0) begin
			// No shift, carry comes from the PSR.
			q = value;
			c = c_in;
		end else begin
			unique case (shift)
				core_pkg::LSL: begin
					q = q_lsl;
					c = value[`CORE_W - shamt];
				end

				core_pkg::LSR: begin
					q = q_lsr;
					c = value[shamt - 1];
				end

				core_pkg::ASR: begin
					q = q_asr;
					c = value[shamt - 1];
				end

				core_pkg::ROR: begin
					q = q_ror;
					c = q_ror[`CORE_W-1];
				end
			endcase
		end
	end

endmodule

// ==== test/core_exec_tb.sv ====
`include "core_cfg.svh"

module core_exec_tb;

	// Strobes and idle cycles of all tests together.
	localparam int N_REQ = 16 + 400 + 300 + 200 + 64 + 128;

	logic               clk;
	logic               rst_n;
	logic               req_valid;
	core_pkg::dp_req    req;
	logic               res_valid;
	core_pkg::dp_result res;
	core_pkg::psr_flags flags;

	core_pkg::dp_result m_res;
	core_pkg::psr_flags m_flags;
	logic [15:0]        lfsr;
	int                 test_errors;
	int                 total_errors;
	int                 tests_run;
	int                 tests_failed;

	core_exec i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.res_valid (res_valid),
		.res       (res),
		.flags     (flags)
	);

	always #50 clk = ~clk;

	// ***********************************************************************
	// Random source
	// ***********************************************************************

	// Taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		int i;
		bits = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic rand_req(output core_pkg::dp_req r);
		logic [31:0] bits;
		take_bits(1, bits);
		r.set_flags = bits[0];
		take_bits(4, bits);
		r.op = core_pkg::alu_op'(bits[3:0]);
		take_bits(`CORE_W, bits);
		r.a = bits[`CORE_W-1:0];
		take_bits(`CORE_W, bits);
		r.b = bits[`CORE_W-1:0];
		take_bits(2, bits);
		r.shift = core_pkg::shift_op'(bits[1:0]);
		take_bits(`CORE_SHW, bits);
		r.shamt = bits[`CORE_SHW-1:0];
	endtask

	// ***********************************************************************
	// Reference model
	// ***********************************************************************

	// Returns {carry, value}.
	function automatic logic [16:0] shift_model(input logic [15:0] value,
		input core_pkg::shift_op op, input logic [3:0] n, input logic c_in);
		logic [31:0] t;
		logic [15:0] r;
		logic        c;
		int          i;
		if (n == 0)
			return {c_in, value};
		case (op)
			core_pkg::LSL: begin
				t = {16'h0, value} << n;
				return {t[16], t[15:0]};
			end
			core_pkg::LSR: begin
				t = {value, 16'h0} >> n;
				return {t[15], t[31:16]};
			end
			core_pkg::ASR: begin
				t = $signed({value, 16'h0}) >>> n;
				return {t[15], t[31:16]};
			end
			default: begin
				r = value;
				c = 1'b0;
				for (i = 0; i < n; i++) begin
					c = r[0];
					r = {r[0], r[15:1]};
				end
				return {c, r};
			end
		endcase
	endfunction

	task automatic model_step(input core_pkg::dp_req r);
		logic [16:0] sh;
		logic [15:0] op2;
		logic [15:0] q;
		logic [16:0] wide;
		logic        arith;
		logic        is_sub;
		logic        cmp;
		int          sa;
		int          sb;
		int          sr;
		int          cin;
		sh = shift_model(r.b, r.shift, r.shamt, m_flags.c);
		op2 = sh[15:0];
		sa = $signed(r.a);
		sb = $signed(op2);
		cin = m_flags.c ? 1 : 0;
		arith = 1'b1;
		is_sub = 1'b1;
		wide = '0;
		sr = 0;
		cmp = (r.op[3:2] == 2'b10);
		case (r.op)
			core_pkg::ADD, core_pkg::CMN, core_pkg::ADC: begin
				is_sub = 1'b0;
				wide = {1'b0, r.a} + {1'b0, op2} + ((r.op == core_pkg::ADC) ? cin : 0);
				sr = sa + sb + ((r.op == core_pkg::ADC) ? cin : 0);
			end
			core_pkg::SUB, core_pkg::CMP, core_pkg::SBC: begin
				wide = {1'b0, r.a} - {1'b0, op2} - ((r.op == core_pkg::SBC) ? 1 - cin : 0);
				sr = sa - sb - ((r.op == core_pkg::SBC) ? 1 - cin : 0);
			end
			core_pkg::RSB, core_pkg::RSC: begin
				wide = {1'b0, op2} - {1'b0, r.a} - ((r.op == core_pkg::RSC) ? 1 - cin : 0);
				sr = sb - sa - ((r.op == core_pkg::RSC) ? 1 - cin : 0);
			end
			default:
				arith = 1'b0;
		endcase
		case (r.op)
			core_pkg::AND, core_pkg::TST: q = r.a & op2;
			core_pkg::EOR, core_pkg::TEQ: q = r.a ^ op2;
			core_pkg::ORR:                q = r.a | op2;
			core_pkg::MOV:                q = op2;
			core_pkg::BIC:                q = r.a & ~op2;
			core_pkg::MVN:                q = ~op2;
			default:                      q = wide[15:0];
		endcase
		if (r.set_flags || cmp) begin
			m_flags.n = q[15];
			m_flags.z = (q == 16'h0);
			m_flags.c = arith ? (is_sub ? !wide[16] : wide[16]) : sh[16];
			if (arith)
				m_flags.v = (sr > 32767) || (sr < -32768);
		end
		m_res.q = q;
		m_res.write = !cmp;
	endtask

	// ***********************************************************************
	// Checks and drivers
	// ***********************************************************************

	task automatic check_res(input string name, input core_pkg::dp_result exp,
		input core_pkg::dp_result act);
		if (act !== exp) begin
			$display("Fail %s: expected q=%h write=%b, actual q=%h write=%b",
				name, exp.q, exp.write, act.q, act.write);
			test_errors++;
		end
	endtask

	task automatic check_flags(input string name, input core_pkg::psr_flags exp,
		input core_pkg::psr_flags act);
		if (act !== exp) begin
			$display("Fail %s: expected nzcv=%b, actual nzcv=%b", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_valid(input string name, input logic exp);
		if (res_valid !== exp) begin
			if (exp)
				$display("%s: res_valid did not rise one cycle after the request", name);
			else
				$display("%s: res_valid was high with no request the cycle before", name);
			test_errors++;
		end
	endtask

	// Called on a falling edge; returns on the next falling edge.
	task automatic send(input string name, input core_pkg::dp_req r);
		req_valid = 1'b1;
		req = r;
		@(posedge clk);
		@(negedge clk);
		model_step(r);
		check_valid(name, 1'b1);
		check_res(name, m_res, res);
		check_flags(name, m_flags, flags);
	endtask

	task automatic idle(input string name);
		core_pkg::dp_req r;
		rand_req(r);
		req_valid = 1'b0;
		req = r;
		@(posedge clk);
		@(negedge clk);
		check_valid(name, 1'b0);
		check_res(name, m_res, res);
		check_flags(name, m_flags, flags);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// ***********************************************************************
	// Tests
	// ***********************************************************************

	initial begin
		repeat (N_REQ * 4 + 10) @(posedge clk);
		$display("watchdog expired before the tests completed");
		$display("tests failed");
		$finish;
	end

	initial begin
		core_pkg::dp_req r;
		logic [31:0]     bits;
		int              i;
		clk = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		lfsr = 16'd11948;
		m_res = '0;
		m_flags = '0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		check_valid("reset", 1'b0);
		check_res("reset", '0, res);
		check_flags("reset", '0, flags);
		for (i = 0; i < 8; i++) begin
			rand_req(r);
			send("reset", r);
			idle("reset");
		end
		finish_test("reset");

		// Logical ops with no shift.
		for (i = 0; i < 200; i++) begin
			// A CMN before each logical op gives it a fresh C and V.
			rand_req(r);
			r.op = core_pkg::CMN;
			send("logical", r);
			rand_req(r);
			take_bits(3, bits);
			bits = bits % 6;
			r.op = core_pkg::alu_op'((bits < 2) ? bits[3:0] : bits[3:0] + 4'd10);
			r.shamt = '0;
			r.set_flags = 1'b1;
			send("logical", r);
		end
		finish_test("logical");

		for (i = 0; i < 300; i++) begin
			rand_req(r);
			take_bits(3, bits);
			r.op = core_pkg::alu_op'(bits % 6 + 2);
			r.set_flags = 1'b1;
			send("arith", r);
		end
		finish_test("arith");

		for (i = 0; i < 200; i++) begin
			rand_req(r);
			r.op = core_pkg::MOV;
			r.set_flags = 1'b1;
			send("shift", r);
		end
		finish_test("shift");

		for (i = 0; i < 64; i++) begin
			rand_req(r);
			r.op = core_pkg::alu_op'({2'b10, r.op[1:0]});
			send("compare", r);
		end
		finish_test("compare");

		// Non-compare ops without set_flags, each followed by a hold cycle.
		for (i = 0; i < 64; i++) begin
			rand_req(r);
			if (r.op[3:2] == 2'b10)
				r.op = core_pkg::alu_op'(r.op | 4'h4);
			r.set_flags = 1'b0;
			send("hold", r);
			idle("hold");
		end
		finish_test("hold");

		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/core_pkg.sv
hw/core_alu_add.sv
hw/core_shifter.sv
hw/core_alu.sv
hw/core_exec.sv
test/core_exec_tb.sv
